// File: rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// dispatch and retire width
`define ROB_N 2

// buffer depth
`define ROB_SZ 16

// completion buses
`define ROB_CDB_SZ 2

// entry index wide enough for ROB_SZ entries
`define ROB_IDX_W 4

// occupancy is one bit wider than the index
`define ROB_CNT_W 5

`define ROB_ALERT `ROB_N          // almost-full margin

`define ROB_ADDR_W 32

`define ROB_PRN_W 6               // physical register number
`define ROB_ARN_W 5               // architectural register number

`endif

// File: rob_pkg.sv
`default_nettype none
`include "rob_consts.svh"

package rob_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    typedef struct packed {
        logic                   executed;
        logic                   mispredicted;
        logic                   is_branch;
        logic                   predicted_taken;
        logic                   is_store;
        logic                   halt;
        logic                   illegal;
        logic [`ROB_PRN_W-1:0]  dest_prn;
        logic [`ROB_ARN_W-1:0]  dest_arn;
        logic [`ROB_ADDR_W-1:0] pc;
        logic [`ROB_ADDR_W-1:0] npc;        // predicted, then resolved target
    } rob_entry_t;

    typedef struct packed {
        logic                   valid;
        logic                   is_branch;
        logic                   predicted_taken;
        logic                   is_store;
        logic                   halt;
        logic                   illegal;
        logic [`ROB_PRN_W-1:0]  dest_prn;
        logic [`ROB_ARN_W-1:0]  dest_arn;
        logic [`ROB_ADDR_W-1:0] pc;
        logic [`ROB_ADDR_W-1:0] npc;
    } rob_dispatch_t;

    typedef struct packed {
        logic                   valid;
        rob_idx_t               robn;
        logic                   branch_taken;
        logic [`ROB_ADDR_W-1:0] target_addr;
    } rob_cdb_t;

    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } rob_commit_t;

    // circular index step for a step below ROB_SZ
    function automatic rob_idx_t rob_wrap(input rob_idx_t ptr, input int unsigned step);
        int unsigned sum;
        sum = ptr + step;
        if (sum >= `ROB_SZ) begin
            sum = sum - `ROB_SZ;
        end
        return rob_idx_t'(sum);
    endfunction

endpackage

`default_nettype wire

// File: rob_pointers.sv
`default_nettype none
`include "rob_consts.svh"

module rob_pointers
    import rob_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  clear,
    input  wire logic [`ROB_CNT_W-1:0] dispatch_count,
    input  wire logic [`ROB_CNT_W-1:0] retire_count,
    output rob_idx_t                   head,
    output rob_idx_t                   tail,
    output logic      [`ROB_CNT_W-1:0] count,
    output logic                       almost_full,
    output rob_idx_t  [`ROB_N-1:0]     tail_entries
);

    rob_idx_t                   head_next;
    rob_idx_t                   tail_next;
    logic     [`ROB_CNT_W-1:0] count_next;

    always_comb begin
        head_next  = rob_wrap(head, retire_count);
        tail_next  = rob_wrap(tail, dispatch_count);
        count_next = count + dispatch_count - retire_count;
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin      // mispredict empties the buffer
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head_next;
            tail  <= tail_next;
            count <= count_next;
        end
    end

    // alarm leaves room for one full dispatch group already in flight
    assign almost_full = (count > (`ROB_SZ - `ROB_ALERT));

    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            tail_entries[i] = rob_wrap(tail, i);   // slots this cycle's dispatch lands in
        end
    end

endmodule

`default_nettype wire

// File: rob_entry_array.sv
`default_nettype none
`include "rob_consts.svh"

module rob_entry_array
    import rob_pkg::*;
(
    input  wire logic                             clock,
    input  wire logic                             reset,
    input  wire logic                             clear,
    input  wire logic                             dispatch_enable,
    input  wire rob_dispatch_t [`ROB_N-1:0]       dispatch,
    input  wire rob_cdb_t      [`ROB_CDB_SZ-1:0]  cdb,
    input  wire rob_idx_t                         tail,
    output rob_entry_t         [`ROB_SZ-1:0]      entries,
    output logic               [`ROB_CNT_W-1:0]   dispatch_count
);

    rob_entry_t [`ROB_SZ-1:0] entries_next;

    always_comb begin
        int unsigned taken;
        rob_idx_t    slot;
        rob_idx_t    target;
        entries_next = entries;
        taken        = 0;
        slot         = tail;
        target       = '0;

        // valid slots pack together from the tail
        for (int i = 0; i < `ROB_N; i++) begin
            if (dispatch_enable && dispatch[i].valid) begin
                slot = rob_wrap(tail, taken);
                entries_next[slot] = '{
                    executed:        1'b0,
                    mispredicted:    1'b0,
                    is_branch:       dispatch[i].is_branch,
                    predicted_taken: dispatch[i].predicted_taken,
                    is_store:        dispatch[i].is_store,
                    halt:            dispatch[i].halt,
                    illegal:         dispatch[i].illegal,
                    dest_prn:        dispatch[i].dest_prn,
                    dest_arn:        dispatch[i].dest_arn,
                    pc:              dispatch[i].pc,
                    npc:             dispatch[i].npc
                };
                taken++;
            end
        end
        dispatch_count = `ROB_CNT_W'(taken);

        for (int c = 0; c < `ROB_CDB_SZ; c++) begin
            if (cdb[c].valid) begin
                target = cdb[c].robn;
                entries_next[target].executed = 1'b1;
                entries_next[target].npc      = cdb[c].target_addr;   // resolved next pc
                entries_next[target].mispredicted = entries_next[target].is_branch &&
                    (cdb[c].branch_taken != entries_next[target].predicted_taken);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            entries <= '0;
        end else begin
            entries <= entries_next;
        end
    end

endmodule

`default_nettype wire

// File: rob_retire.sv
`default_nettype none
`include "rob_consts.svh"

module rob_retire
    import rob_pkg::*;
(
    input  wire rob_entry_t  [`ROB_SZ-1:0]    entries,
    input  wire rob_idx_t                     head,
    input  wire logic        [`ROB_CNT_W-1:0] count,
    input  wire logic                         retire_enable,
    output rob_commit_t      [`ROB_N-1:0]     commit,
    output logic             [`ROB_CNT_W-1:0] retire_count,
    output logic                              retire_mispredict,
    output logic                              retire_halt
);

    always_comb begin
        rob_idx_t    idx;
        logic        open;
        int unsigned n;
        open              = retire_enable;
        n                 = 0;
        idx               = head;
        retire_mispredict = 1'b0;
        retire_halt       = 1'b0;

        for (int i = 0; i < `ROB_N; i++) begin
            idx             = rob_wrap(head, i);
            commit[i].entry = entries[idx];
            commit[i].valid = 1'b0;
            if (open && (i < count) && entries[idx].executed) begin
                commit[i].valid = 1'b1;
                n++;
                if (entries[idx].mispredicted) begin
                    retire_mispredict = 1'b1;      // younger entries are wrong path
                    open              = 1'b0;
                end else if (entries[idx].halt) begin
                    retire_halt = 1'b1;
                    open        = 1'b0;
                end
            end else begin
                open = 1'b0;                       // in-order retirement stops at first hole
            end
        end

        retire_count = `ROB_CNT_W'(n);
    end

endmodule

`default_nettype wire

// File: rob_recovery_fsm.sv
`default_nettype none

module rob_recovery_fsm (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic almost_full,
    input  wire logic retire_mispredict,
    input  wire logic retire_halt,
    output logic      dispatch_enable,
    output logic      retire_enable,
    output logic      clear,
    output logic      flush,
    output logic      halted
);

    typedef enum logic [1:0] {
        ST_RUN,
        ST_RECOVER,
        ST_HALTED
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_RUN: begin
                if (retire_mispredict) begin
                    state_next = ST_RECOVER;
                end else if (retire_halt) begin
                    state_next = ST_HALTED;
                end
            end
            ST_RECOVER: state_next = ST_RUN;          // single flush cycle
            ST_HALTED:  state_next = ST_HALTED;       // only reset leaves
            default:    state_next = ST_RUN;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_RUN;
        end else begin
            state <= state_next;
        end
    end

    assign dispatch_enable = (state == ST_RUN) && !almost_full;
    assign retire_enable   = (state == ST_RUN);
    // held through recover so stray completions never land
    assign clear           = retire_mispredict || (state == ST_RECOVER);
    assign flush           = (state == ST_RECOVER);
    assign halted          = (state == ST_HALTED);

endmodule

`default_nettype wire

// File: rob_top.sv
`default_nettype none
`include "rob_consts.svh"

module rob_top
    import rob_pkg::*;
(
    input  wire logic                            clock,
    input  wire logic                            reset,
    input  wire rob_dispatch_t [`ROB_N-1:0]      dispatch,
    input  wire rob_cdb_t      [`ROB_CDB_SZ-1:0] cdb,
    output rob_commit_t        [`ROB_N-1:0]      commit,
    output rob_idx_t           [`ROB_N-1:0]      tail_entries,
    output logic                                 almost_full,
    output logic                                 flush,
    output logic                                 halted
);

    rob_idx_t                   head;
    rob_idx_t                   tail;
    logic     [`ROB_CNT_W-1:0]  count;
    logic     [`ROB_CNT_W-1:0]  dispatch_count;
    logic     [`ROB_CNT_W-1:0]  retire_count;
    rob_entry_t [`ROB_SZ-1:0]   entries;
    logic                       dispatch_enable;
    logic                       retire_enable;
    logic                       clear;
    logic                       retire_mispredict;
    logic                       retire_halt;

    rob_pointers pointers0 (
        .clock          (clock),
        .reset          (reset),
        .clear          (clear),
        .dispatch_count (dispatch_count),
        .retire_count   (retire_count),
        .head           (head),
        .tail           (tail),
        .count          (count),
        .almost_full    (almost_full),
        .tail_entries   (tail_entries)
    );

    rob_entry_array entry_array0 (
        .clock           (clock),
        .reset           (reset),
        .clear           (clear),
        .dispatch_enable (dispatch_enable),
        .dispatch        (dispatch),
        .cdb             (cdb),
        .tail            (tail),
        .entries         (entries),
        .dispatch_count  (dispatch_count)
    );

    rob_retire retire0 (
        .entries           (entries),
        .head              (head),
        .count             (count),
        .retire_enable     (retire_enable),
        .commit            (commit),
        .retire_count      (retire_count),
        .retire_mispredict (retire_mispredict),
        .retire_halt       (retire_halt)
    );

    rob_recovery_fsm recovery0 (
        .clock             (clock),
        .reset             (reset),
        .almost_full       (almost_full),
        .retire_mispredict (retire_mispredict),
        .retire_halt       (retire_halt),
        .dispatch_enable   (dispatch_enable),
        .retire_enable     (retire_enable),
        .clear             (clear),
        .flush             (flush),
        .halted            (halted)
    );

endmodule

`default_nettype wire

// File: rob_asserts.sv
`default_nettype none
`include "rob_consts.svh"

module rob_asserts
    import rob_pkg::*;
(
    input wire logic                     clock,
    input wire logic                     reset,
    input wire rob_commit_t [`ROB_N-1:0] commit,
    input wire logic                     flush,
    input wire logic                     halted
);

    logic [`ROB_N-1:0] commit_valid;

    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            commit_valid[i] = commit[i].valid;
        end
    end

    // recover lasts a single cycle
    flush_one_cycle: assert property (@(posedge clock) disable iff (reset)
        flush |=> !flush)
        else $error("flush high in two consecutive cycles");

    for (genvar i = 1; i < `ROB_N; i++) begin : g_order
        commit_in_order: assert property (@(posedge clock) disable iff (reset)
            commit_valid[i] |-> commit_valid[i - 1])
            else $error("commit slot %0d valid after an empty slot", i);
    end

    no_commit_halted: assert property (@(posedge clock) disable iff (reset)
        halted |-> (commit_valid == '0))
        else $error("commit valid while halted");

endmodule

`default_nettype wire

// File: rob_tb.sv
`default_nettype none
`include "rob_consts.svh"

module rob_tb
    import rob_pkg::*;
();

    typedef struct packed {
        int   test;
        int   ndisp;
        int   kind0;        // 0 plain, 1 branch not taken, 2 branch taken, 3 halt
        int   kind1;
        int   c0;           // seq to complete, -1 none, -2 random pick
        logic t0;
        int   c1;
        logic t1;
        int   exp_ret;      // -1 leaves the count to the model
        logic exp_flush;
        logic exp_halted;
    } step_t;

    typedef struct packed {
        int         seq;
        rob_idx_t   robn;
        rob_entry_t e;
    } model_t;

    logic                            clock;
    logic                            reset;
    rob_dispatch_t [`ROB_N-1:0]      dispatch;
    rob_cdb_t      [`ROB_CDB_SZ-1:0] cdb;
    rob_commit_t   [`ROB_N-1:0]      commit;
    rob_idx_t      [`ROB_N-1:0]      tail_entries;
    logic                            almost_full;
    logic                            flush;
    logic                            halted;

    step_t       steps[$];
    model_t      model[$];
    logic [31:0] rng;
    int          m_tail;
    logic        m_recover;
    logic        m_halted;
    int          checks;
    int          errors;
    int          test_errors;
    int          limit;
    int          cycles;

    rob_top dut0 (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .commit       (commit),
        .tail_entries (tail_entries),
        .almost_full  (almost_full),
        .flush        (flush),
        .halted       (halted)
    );

    bind rob_top rob_asserts asserts0 (
        .clock  (clock),
        .reset  (reset),
        .commit (commit),
        .flush  (flush),
        .halted (halted)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] target_of(input logic [31:0] pc, input logic taken);
        return taken ? pc + 32'h40 : pc + 32'h4;
    endfunction

    function automatic rob_dispatch_t make_slot(input int seq, input int kind);
        rob_dispatch_t d;
        d                 = '0;
        d.valid           = 1'b1;
        d.is_branch       = (kind == 1) || (kind == 2);
        d.predicted_taken = (kind == 2);
        d.halt            = (kind == 3);
        d.is_store        = (seq % 3 == 0);    // carried only
        d.dest_prn        = `ROB_PRN_W'(seq);
        d.dest_arn        = `ROB_ARN_W'(seq);
        d.pc              = 32'h1000 + 32'(seq * 4);
        d.npc             = d.pc + 32'h4;
        return d;
    endfunction

    function automatic rob_entry_t entry_of(input rob_dispatch_t d);
        return '{1'b0, 1'b0, d.is_branch, d.predicted_taken, d.is_store, d.halt,
                 d.illegal, d.dest_prn, d.dest_arn, d.pc, d.npc};
    endfunction

    function automatic int find_seq(input int seq);
        for (int i = 0; i < model.size(); i++) begin
            if (model[i].seq == seq) begin
                return i;
            end
        end
        return -1;
    endfunction

    // random entry still waiting for its result
    function automatic int pick_pending();
        int cand;
        int n;
        cand = 0;
        for (int i = 0; i < model.size(); i++) begin
            cand += int'(!model[i].e.executed);
        end
        if (cand == 0) begin
            return -1;
        end
        rng = xorshift(rng);
        n   = int'(rng % 32'(cand));
        for (int i = 0; i < model.size(); i++) begin
            if (!model[i].e.executed) begin
                if (n == 0) begin
                    return i;
                end
                n--;
            end
        end
        return -1;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "reset state";
            2:       return "dispatch and reverse completion";
            3:       return "almost full back-pressure";
            4:       return "mispredicted branch";
            5:       return "predicted branch";
            6:       return "halt";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic complete(input int port, input int code, input logic taken);
        int          idx;
        logic [31:0] target;
        idx = (code == -2) ? pick_pending() : (code >= 0) ? find_seq(code) : -1;
        if (idx >= 0) begin
            target    = target_of(model[idx].e.pc, taken);
            cdb[port] = '{1'b1, model[idx].robn, taken, target};
            model[idx].e.executed     = 1'b1;
            model[idx].e.npc          = target;
            model[idx].e.mispredicted = model[idx].e.is_branch &&
                (taken != model[idx].e.predicted_taken);
        end
    endtask

    task automatic add_step(input int test, input int ndisp, input int kind0, input int kind1,
                            input int c0, input logic t0, input int c1, input logic t1,
                            input int exp_ret, input logic exp_flush, input logic exp_halted);
        steps.push_back('{test, ndisp, kind0, kind1, c0, t0, c1, t1,
                          exp_ret, exp_flush, exp_halted});
    endtask

    task automatic build_table();
        //      test disp k0 k1  c0 t0  c1 t1 ret fl ha
        add_step(1, 0, 0, 0, -1, 0, -1, 0,  0, 0, 0);
        add_step(2, 2, 0, 0, -1, 0, -1, 0,  0, 0, 0);
        add_step(2, 2, 0, 0,  1, 0, -1, 0,  0, 0, 0);
        add_step(2, 0, 0, 0,  3, 0,  2, 0,  0, 0, 0);
        add_step(2, 0, 0, 0,  0, 0, -1, 0,  0, 0, 0);
        add_step(2, 0, 0, 0, -1, 0, -1, 0,  2, 0, 0);
        add_step(2, 0, 0, 0, -1, 0, -1, 0,  2, 0, 0);
        repeat (10) add_step(3, 2, 0, 0, -1, 0, -1, 0,  0, 0, 0);  // last two land on a full buffer
        repeat (16) add_step(3, 0, 0, 0, -2, 0, -2, 0, -1, 0, 0);
        add_step(3, 2, 0, 0, -1, 0, -1, 0,  0, 0, 0);
        add_step(3, 0, 0, 0, 24, 0, 25, 0,  0, 0, 0);
        add_step(3, 0, 0, 0, -1, 0, -1, 0,  2, 0, 0);
        add_step(4, 2, 1, 0, -1, 0, -1, 0,  0, 0, 0);
        add_step(4, 1, 0, 0, 26, 1, 27, 0,  0, 0, 0);
        add_step(4, 0, 0, 0, 28, 0, -1, 0,  1, 0, 0);
        add_step(4, 2, 0, 0, -1, 0, -1, 0,  0, 1, 0);
        add_step(4, 2, 0, 0, -1, 0, -1, 0,  0, 0, 0);
        add_step(5, 1, 2, 0, 31, 0, 32, 0,  0, 0, 0);
        add_step(5, 0, 0, 0, 33, 1, -1, 0,  2, 0, 0);
        add_step(5, 0, 0, 0, -1, 0, -1, 0,  1, 0, 0);
        add_step(5, 0, 0, 0, -1, 0, -1, 0,  0, 0, 0);
        add_step(6, 2, 0, 3, -1, 0, -1, 0,  0, 0, 0);
        add_step(6, 2, 0, 0, 35, 0, 34, 0,  0, 0, 0);
        add_step(6, 0, 0, 0, 36, 0, 37, 0,  2, 0, 0);
        add_step(6, 2, 0, 0, -1, 0, -1, 0,  0, 0, 1);
        add_step(6, 0, 0, 0, -1, 0, -1, 0,  0, 0, 1);
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("TIMEOUT: run did not finish within %0d cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        step_t  st;
        model_t m;
        int     exp_n;
        int     got_n;
        int     next_seq;
        logic   open;
        logic   exp_misp;
        logic   exp_halt;
        logic   full;

        reset       = 1'b1;
        dispatch    = '0;
        cdb         = '0;
        rng         = 32'd45;
        m_tail      = 0;
        m_recover   = 1'b0;
        m_halted    = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        next_seq    = 0;
        build_table();
        limit = steps.size() + 50;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int k = 0; k < steps.size(); k++) begin
            @(posedge clock);
            #1;
            st       = steps[k];
            full     = model.size() > (`ROB_SZ - `ROB_ALERT);
            exp_n    = 0;
            exp_misp = 1'b0;
            exp_halt = 1'b0;
            open     = !m_recover && !m_halted;
            for (int i = 0; i < `ROB_N; i++) begin     // in-order run from the head
                if (open && i < model.size() && model[i].e.executed) begin
                    exp_n++;
                    exp_misp = model[i].e.mispredicted;
                    exp_halt = !exp_misp && model[i].e.halt;
                    open     = !exp_misp && !exp_halt;
                end else begin
                    open = 1'b0;
                end
            end

            got_n = 0;
            check_value("flush", 32'(flush), 32'(m_recover));
            check_value("halted", 32'(halted), 32'(m_halted));
            check_value("almost_full", 32'(almost_full), 32'(full));
            for (int i = 0; i < `ROB_N; i++) begin
                got_n += int'(commit[i].valid);
                check_value($sformatf("tail_entries[%0d]", i), 32'(tail_entries[i]),
                            32'((m_tail + i) % `ROB_SZ));
                check_value($sformatf("commit[%0d].valid", i), 32'(commit[i].valid),
                            32'(i < exp_n));
                if (commit[i].valid && i < exp_n) begin
                    check_value($sformatf("commit[%0d].pc", i), commit[i].entry.pc,
                                model[i].e.pc);
                    check_value($sformatf("commit[%0d].npc", i), commit[i].entry.npc,
                                model[i].e.npc);
                    check_value($sformatf("commit[%0d].mispredicted", i),
                                32'(commit[i].entry.mispredicted),
                                32'(model[i].e.mispredicted));
                    // flags and register numbers above pc and npc
                    check_value($sformatf("commit[%0d].flags_dest", i),
                                32'(commit[i].entry >> (2 * `ROB_ADDR_W)),
                                32'(model[i].e >> (2 * `ROB_ADDR_W)));
                end
            end
            if (st.exp_ret >= 0) begin
                check_value("retire count", 32'(got_n), 32'(st.exp_ret));
            end
            check_value("flush (table)", 32'(flush), 32'(st.exp_flush));
            check_value("halted (table)", 32'(halted), 32'(st.exp_halted));

            dispatch = '0;
            cdb      = '0;
            for (int i = 0; i < st.ndisp; i++) begin
                dispatch[i] = make_slot(next_seq + i, (i == 0) ? st.kind0 : st.kind1);
            end
            complete(0, st.c0, st.t0);
            complete(1, st.c1, st.t1);

            if (m_recover) begin
                m_recover = 1'b0;                      // inputs dropped during flush
            end else if (!m_halted) begin
                for (int i = 0; i < exp_n; i++) begin
                    model.delete(0);
                end
                if (exp_misp) begin
                    model.delete();
                    m_tail    = 0;
                    m_recover = 1'b1;
                end else begin
                    m_halted = exp_halt;
                    for (int i = 0; i < st.ndisp && !full; i++) begin
                        m.seq  = next_seq + i;
                        m.robn = tail_entries[i];
                        m.e    = entry_of(dispatch[i]);
                        model.push_back(m);
                        m_tail = (m_tail + 1) % `ROB_SZ;
                    end
                end
            end
            next_seq += st.ndisp;

            if (k == steps.size() - 1 || steps[k + 1].test != st.test) begin
                $display("test %0d %s: %0d errors", st.test, test_name(st.test), test_errors);
                test_errors = 0;
            end
        end

        $display("steps %0d, checks %0d, errors %0d", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
rob_pkg.sv
rob_pointers.sv
rob_entry_array.sv
rob_retire.sv
rob_recovery_fsm.sv
rob_top.sv
rob_asserts.sv
rob_tb.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --assert --timing -j 0
TOP      := rob_tb
FILELIST := src.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
